/* decode_execute_top.f */
logic/rv_isa_pkg.sv
logic/ex_ctrl_pkg.sv
logic/inst_decode.sv
logic/id_ex_reg.sv
logic/alu.sv
logic/branch_unit.sv
logic/ex_writeback.sv
logic/decode_execute_top.sv
bench/decode_execute_asserts.sv
bench/decode_execute_tb.sv

/* Makefile */
SIM = obj_dir/Vdecode_execute_tb

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): decode_execute_top.f $(wildcard logic/*.sv bench/*.sv)
	verilator --binary --timing --assert --top-module decode_execute_tb -f decode_execute_top.f

run: compile
	-$(SIM) > sim.log 2>&1
	@cat sim.log
	@if grep -q "RESULT: FAIL" sim.log; then exit 1; fi
	@grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/decode_execute_tb.sv */
module decode_execute_tb
    import rv_isa_pkg::*;
();

    localparam int XLEN             = 64;
    localparam int CLK_PERIOD       = 8;
    localparam int RESET_CYCLES     = 5;
    localparam int VECTORS_PER_TEST = 200;
    localparam int NUM_TESTS        = 6;
    localparam int WATCHDOG_CYCLES  = NUM_TESTS * VECTORS_PER_TEST * 3 + 100;

    localparam int MODE_REG   = 0;
    localparam int MODE_IMM   = 1;
    localparam int MODE_BR    = 2;
    localparam int MODE_MIX   = 3;
    localparam int MODE_NOEFF = 4;

    logic            clk = 1'b0;
    logic            reset_i;
    logic            in_valid_i;
    logic [31:0]     instr_i;
    logic [XLEN-1:0] pc_i;
    logic [XLEN-1:0] rs1_data_i;
    logic [XLEN-1:0] rs2_data_i;
    logic            stall_i;
    logic            flush_i;
    logic            wb_valid_o;
    logic [4:0]      wb_rd_o;
    logic [XLEN-1:0] wb_data_o;
    logic            redirect_o;
    logic [XLEN-1:0] redirect_pc_o;

    logic [63:0] rng_state;
    int          errors;
    int          checks;

    // model of the id/ex stage
    logic        ex_v;
    logic        ex_we;
    logic [4:0]  ex_rd;
    logic [63:0] ex_data;
    logic        ex_taken;
    logic [63:0] ex_target;
    // model of the registered outputs
    logic        exp_wb_valid;
    logic        exp_redirect;
    logic [4:0]  exp_rd;
    logic [63:0] exp_data;
    logic [63:0] exp_target;

    decode_execute_top #(.XLEN(XLEN)) dut_i (
        .clk           (clk),
        .reset_i       (reset_i),
        .in_valid_i    (in_valid_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .rs1_data_i    (rs1_data_i),
        .rs2_data_i    (rs2_data_i),
        .stall_i       (stall_i),
        .flush_i       (flush_i),
        .wb_valid_o    (wb_valid_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 64'd6364136223846793005 + 64'd1442695040888963407;
        return rng_state[63:32]; // upper half, low bits are weak
    endfunction

    function automatic logic [63:0] rand64();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_rand();
        lo = next_rand();
        return {hi, lo};
    endfunction

    function automatic logic opcode_known(input logic [6:0] op);
        return op inside {OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH};
    endfunction

    function automatic logic [31:0] make_instr(input int mode);
        logic [31:0] w;
        logic [31:0] r;
        int          kind;
        w = next_rand();
        r = next_rand();
        case (mode)
            MODE_REG:   kind = 0;
            MODE_IMM:   kind = (r[1] == 1'b0) ? 1 : 2 + int'(r[0]);
            MODE_BR:    kind = (r[1] == 1'b0) ? 4 : 5 + int'(r[0]);
            MODE_NOEFF: kind = int'(r[1:0]); // non-jump writers only
            default:    kind = int'(r[2:0] % 3'd7);
        endcase
        case (kind)
            0: begin
                w[6:0]   = OPC_OP;
                w[31:25] = (r[8] && (w[14:12] == F3_ADD_SUB || w[14:12] == F3_SRL_SRA)) ?
                           FUNCT7_ALT : 7'd0;
            end
            1: begin
                w[6:0] = OPC_OP_IMM;
                if (w[14:12] == F3_SLL) begin
                    w[31:26] = 6'd0;
                end else if (w[14:12] == F3_SRL_SRA) begin
                    w[31:26] = r[8] ? 6'b010000 : 6'd0; // srai or srli
                end
            end
            2: w[6:0] = OPC_LUI;
            3: w[6:0] = OPC_AUIPC;
            4: begin
                w[6:0] = OPC_BRANCH;
                if (w[14:13] == 2'b01) w[14:13] = 2'b00; // skip reserved funct3
            end
            5: w[6:0] = OPC_JAL;
            default: begin
                w[6:0]   = OPC_JALR;
                w[14:12] = 3'b000;
            end
        endcase
        if (mode == MODE_NOEFF) begin
            w[11:7] = 5'd0;
            if (r[9]) begin
                w[6:0] = r[22:16];
                while (opcode_known(w[6:0])) begin
                    r = next_rand();
                    w[6:0] = r[22:16];
                end
            end
        end
        return w;
    endfunction

    function automatic logic [63:0] alu_model(input logic [2:0] f3, input logic alt,
                                              input logic [63:0] x, input logic [63:0] y);
        logic signed [63:0] sx;
        logic        [63:0] r;
        sx = x;
        case (f3)
            F3_ADD_SUB: r = alt ? x - y : x + y;
            F3_SLL:     r = x << y[5:0];
            F3_SLT:     r = {63'd0, $signed(x) < $signed(y)};
            F3_SLTU:    r = {63'd0, x < y};
            F3_XOR:     r = x ^ y;
            F3_SRL_SRA: begin
                if (alt) r = sx >>> y[5:0];
                else r = x >> y[5:0];
            end
            F3_OR:      r = x | y;
            default:    r = x & y;
        endcase
        return r;
    endfunction

    function automatic logic branch_model(input logic [2:0] f3, input logic [63:0] x,
                                          input logic [63:0] y);
        logic t;
        case (f3)
            F3_BEQ:  t = (x == y);
            F3_BNE:  t = (x != y);
            F3_BLT:  t = ($signed(x) < $signed(y));
            F3_BGE:  t = ($signed(x) >= $signed(y));
            F3_BLTU: t = (x < y);
            F3_BGEU: t = (x >= y);
            default: t = 1'b0;
        endcase
        return t;
    endfunction

    task automatic predict(input logic [31:0] ins, input logic [63:0] pc,
                           input logic [63:0] a, input logic [63:0] b,
                           output logic we, output logic [4:0] rd, output logic [63:0] data,
                           output logic taken, output logic [63:0] target);
        logic [63:0] imm_i;
        logic [63:0] imm_u;
        logic [63:0] imm_b;
        logic [63:0] imm_j;
        imm_i  = {{52{ins[31]}}, ins[31:20]};
        imm_u  = {{32{ins[31]}}, ins[31:12], 12'h000};
        imm_b  = {{51{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j  = {{43{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        rd     = ins[11:7];
        we     = 1'b0;
        taken  = 1'b0;
        data   = 64'd0;
        target = 64'd0;
        case (ins[6:0])
            OPC_OP: begin
                we   = 1'b1;
                data = alu_model(ins[14:12], ins[31:25] == FUNCT7_ALT, a, b);
            end
            OPC_OP_IMM: begin
                we   = 1'b1;
                data = alu_model(ins[14:12], ins[30] && ins[14:12] == F3_SRL_SRA, a, imm_i);
            end
            OPC_LUI: begin
                we   = 1'b1;
                data = imm_u;
            end
            OPC_AUIPC: begin
                we   = 1'b1;
                data = pc + imm_u;
            end
            OPC_JAL: begin
                we     = 1'b1;
                data   = pc + 64'd4;
                taken  = 1'b1;
                target = pc + imm_j;
            end
            OPC_JALR: begin
                we     = 1'b1;
                data   = pc + 64'd4;
                taken  = 1'b1;
                target = (a + imm_i) & ~64'd1;
            end
            OPC_BRANCH: begin
                taken  = branch_model(ins[14:12], a, b);
                target = pc + imm_b;
            end
            default: ;
        endcase
        if (rd == 5'd0) we = 1'b0;
    endtask

    // advance the model by one clock edge, using the inputs seen at that edge
    task automatic step_model();
        logic        we;
        logic [4:0]  rd;
        logic [63:0] data;
        logic        taken;
        logic [63:0] target;
        if (stall_i) begin
            exp_wb_valid = 1'b0; // bubble
            exp_redirect = 1'b0;
        end else begin
            exp_wb_valid = ex_v && ex_we;
            exp_redirect = ex_v && ex_taken;
            exp_rd       = ex_rd;
            exp_data     = ex_data;
            exp_target   = ex_target;
        end
        predict(instr_i, pc_i, rs1_data_i, rs2_data_i, we, rd, data, taken, target);
        if (flush_i) begin
            ex_v = 1'b0;
        end else if (!stall_i) begin
            ex_v      = in_valid_i;
            ex_we     = we;
            ex_rd     = rd;
            ex_data   = data;
            ex_taken  = taken;
            ex_target = target;
        end
    endtask

    task automatic compare_value(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("** Error: %s expected %h actual %h at %0t", name, expected, actual, $time);
            errors++;
        end
    endtask

    task automatic check_outputs();
        compare_value("wb_valid_o", {63'd0, exp_wb_valid}, {63'd0, wb_valid_o});
        if (exp_wb_valid) begin
            compare_value("wb_rd_o", {59'd0, exp_rd}, {59'd0, wb_rd_o});
            compare_value("wb_data_o", exp_data, wb_data_o);
        end
        compare_value("redirect_o", {63'd0, exp_redirect}, {63'd0, redirect_o});
        if (exp_redirect) compare_value("redirect_pc_o", exp_target, redirect_pc_o);
    endtask

    task automatic drive_inputs(input int mode);
        logic [31:0] r;
        r          = next_rand();
        in_valid_i = (r[2:0] != 3'd0);
        instr_i    = make_instr(mode);
        pc_i       = rand64() & ~64'd3;
        rs1_data_i = rand64();
        rs2_data_i = (r[5:4] == 2'd0) ? rs1_data_i : rand64(); // equal operands for beq
    endtask

    task automatic run_test(input string name, input int mode, input logic use_stall,
                            input logic use_flush);
        int          start_errors;
        int          i;
        logic [31:0] r;
        start_errors = errors;
        for (i = 0; i < VECTORS_PER_TEST; i++) begin
            if (!stall_i) drive_inputs(mode); // upstream holds while stalled
            r       = next_rand();
            stall_i = use_stall && (r[1:0] == 2'd0);
            flush_i = use_flush && (r[4:2] == 3'd0);
            @(posedge clk);
            #1;
            step_model();
            check_outputs();
        end
        in_valid_i = 1'b0;
        stall_i    = 1'b0;
        flush_i    = 1'b0;
        repeat (3) begin
            @(posedge clk);
            #1;
            step_model();
            check_outputs();
        end
        $display("test %s: %0d vectors, %0d errors", name, VECTORS_PER_TEST,
                 errors - start_errors);
    endtask

    initial begin
        rng_state    = 64'd62;
        errors       = 0;
        checks       = 0;
        reset_i      = 1'b1;
        in_valid_i   = 1'b0;
        instr_i      = 32'd0;
        pc_i         = '0;
        rs1_data_i   = '0;
        rs2_data_i   = '0;
        stall_i      = 1'b0;
        flush_i      = 1'b0;
        ex_v         = 1'b0;
        ex_we        = 1'b0;
        ex_taken     = 1'b0;
        exp_wb_valid = 1'b0;
        exp_redirect = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset_i = 1'b0;
        check_outputs(); // outputs idle after reset

        run_test("register alu", MODE_REG, 1'b0, 1'b0);
        run_test("immediate lui auipc", MODE_IMM, 1'b0, 1'b0);
        run_test("branch jump", MODE_BR, 1'b0, 1'b0);
        run_test("stall", MODE_MIX, 1'b1, 1'b0);
        run_test("flush", MODE_MIX, 1'b0, 1'b1);
        run_test("no effect", MODE_NOEFF, 1'b0, 1'b0);

        $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD); // three cycles per vector plus margin
        $display("timeout: the tests did not finish in %0d cycles", WATCHDOG_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* bench/decode_execute_asserts.sv */
module decode_execute_asserts #(
    parameter int XLEN = 64
) (
    input logic            clk,
    input logic            reset_i,
    input logic            stall_i,
    input logic            wb_valid_o,
    input logic [4:0]      wb_rd_o,
    input logic            redirect_o,
    input logic [XLEN-1:0] redirect_pc_o
);

    // a stall or reset edge loads a bubble into the writeback stage
    bubble_after_stall: assert property (
        @(posedge clk) (reset_i || stall_i) |=> (!wb_valid_o && !redirect_o)
    ) else $error("writeback not empty after a stall or reset edge");

    rd_nonzero: assert property (
        @(posedge clk) disable iff (reset_i) wb_valid_o |-> (wb_rd_o != 5'd0)
    ) else $error("writeback to x0");

    target_even: assert property (
        @(posedge clk) disable iff (reset_i) redirect_o |-> !redirect_pc_o[0]
    ) else $error("redirect target has bit 0 set");

endmodule

bind decode_execute_top decode_execute_asserts #(.XLEN(XLEN)) u_asserts (
    .clk           (clk),
    .reset_i       (reset_i),
    .stall_i       (stall_i),
    .wb_valid_o    (wb_valid_o),
    .wb_rd_o       (wb_rd_o),
    .redirect_o    (redirect_o),
    .redirect_pc_o (redirect_pc_o)
);

/* logic/decode_execute_top.sv */
module decode_execute_top
    import ex_ctrl_pkg::*;
#(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            reset_i,
    input  logic            in_valid_i,
    input  logic [31:0]     instr_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] rs1_data_i,
    input  logic [XLEN-1:0] rs2_data_i,
    input  logic            stall_i,
    input  logic            flush_i,
    output logic            wb_valid_o,
    output logic [4:0]      wb_rd_o,
    output logic [XLEN-1:0] wb_data_o,
    output logic            redirect_o,
    output logic [XLEN-1:0] redirect_pc_o
);

    alu_op_e         dec_alu_op;
    src_a_e          dec_src_a;
    src_b_e          dec_src_b;
    br_op_e          dec_br_op;
    wb_sel_e         dec_wb_sel;
    logic            dec_rd_we;
    logic [4:0]      dec_rd;
    logic [31:0]     dec_imm;

    logic            ex_valid;
    logic [XLEN-1:0] ex_pc;
    logic [XLEN-1:0] ex_rs1;
    logic [XLEN-1:0] ex_rs2;
    logic [XLEN-1:0] ex_imm;
    alu_op_e         ex_alu_op;
    src_a_e          ex_src_a;
    src_b_e          ex_src_b;
    br_op_e          ex_br_op;
    wb_sel_e         ex_wb_sel;
    logic            ex_rd_we;
    logic [4:0]      ex_rd;

    logic [XLEN-1:0] alu_result;
    logic            br_taken;
    logic [XLEN-1:0] br_target;

    inst_decode u_decode (
        .instr_i  (instr_i),
        .alu_op_o (dec_alu_op),
        .src_a_o  (dec_src_a),
        .src_b_o  (dec_src_b),
        .br_op_o  (dec_br_op),
        .wb_sel_o (dec_wb_sel),
        .rd_we_o  (dec_rd_we),
        .rd_o     (dec_rd),
        .imm_o    (dec_imm)
    );

    id_ex_reg #(.XLEN(XLEN)) u_id_ex (
        .clk        (clk),
        .reset_i    (reset_i),
        .stall_i    (stall_i),
        .flush_i    (flush_i),
        .valid_i    (in_valid_i),
        .pc_i       (pc_i),
        .rs1_data_i (rs1_data_i),
        .rs2_data_i (rs2_data_i),
        .alu_op_i   (dec_alu_op),
        .src_a_i    (dec_src_a),
        .src_b_i    (dec_src_b),
        .br_op_i    (dec_br_op),
        .wb_sel_i   (dec_wb_sel),
        .rd_we_i    (dec_rd_we),
        .rd_i       (dec_rd),
        .imm_i      (dec_imm),
        .valid_o    (ex_valid),
        .pc_o       (ex_pc),
        .rs1_data_o (ex_rs1),
        .rs2_data_o (ex_rs2),
        .imm_o      (ex_imm),
        .alu_op_o   (ex_alu_op),
        .src_a_o    (ex_src_a),
        .src_b_o    (ex_src_b),
        .br_op_o    (ex_br_op),
        .wb_sel_o   (ex_wb_sel),
        .rd_we_o    (ex_rd_we),
        .rd_o       (ex_rd)
    );

    alu #(.XLEN(XLEN)) u_alu (
        .alu_op_i   (ex_alu_op),
        .src_a_i    (ex_src_a),
        .src_b_i    (ex_src_b),
        .pc_i       (ex_pc),
        .rs1_data_i (ex_rs1),
        .rs2_data_i (ex_rs2),
        .imm_i      (ex_imm),
        .result_o   (alu_result)
    );

    branch_unit #(.XLEN(XLEN)) u_branch (
        .br_op_i    (ex_br_op),
        .pc_i       (ex_pc),
        .rs1_data_i (ex_rs1),
        .rs2_data_i (ex_rs2),
        .imm_i      (ex_imm),
        .taken_o    (br_taken),
        .target_o   (br_target)
    );

    ex_writeback #(.XLEN(XLEN)) u_writeback (
        .clk           (clk),
        .reset_i       (reset_i),
        .stall_i       (stall_i),
        .valid_i       (ex_valid),
        .rd_we_i       (ex_rd_we),
        .rd_i          (ex_rd),
        .wb_sel_i      (ex_wb_sel),
        .pc_i          (ex_pc),
        .alu_result_i  (alu_result),
        .taken_i       (br_taken),
        .target_i      (br_target),
        .wb_valid_o    (wb_valid_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o)
    );

endmodule

/* logic/ex_writeback.sv */
module ex_writeback
    import ex_ctrl_pkg::*;
#(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            reset_i,
    input  logic            stall_i,
    input  logic            valid_i,
    input  logic            rd_we_i,
    input  logic [4:0]      rd_i,
    input  wb_sel_e         wb_sel_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] alu_result_i,
    input  logic            taken_i,
    input  logic [XLEN-1:0] target_i,
    output logic            wb_valid_o,
    output logic [4:0]      wb_rd_o,
    output logic [XLEN-1:0] wb_data_o,
    output logic            redirect_o,
    output logic [XLEN-1:0] redirect_pc_o
);

    logic [XLEN-1:0] link_addr;

    assign link_addr = pc_i + XLEN'(4);

    always_ff @(posedge clk) begin
        if (reset_i || stall_i) begin
            wb_valid_o <= 1'b0; // bubble
            redirect_o <= 1'b0;
        end else begin
            wb_valid_o <= valid_i && rd_we_i;
            redirect_o <= valid_i && taken_i;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd_o       <= rd_i;
        wb_data_o     <= (wb_sel_i == WB_LINK) ? link_addr : alu_result_i;
        redirect_pc_o <= target_i;
    end

endmodule

/* logic/branch_unit.sv */
module branch_unit
    import ex_ctrl_pkg::*;
#(
    parameter int XLEN = 64
) (
    input  br_op_e          br_op_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] rs1_data_i,
    input  logic [XLEN-1:0] rs2_data_i,
    input  logic [XLEN-1:0] imm_i,
    output logic            taken_o,
    output logic [XLEN-1:0] target_o
);

    logic            eq;
    logic            lt_s;
    logic            lt_u;
    logic [XLEN-1:0] base;
    logic [XLEN-1:0] sum;

    assign eq   = (rs1_data_i == rs2_data_i);
    assign lt_s = ($signed(rs1_data_i) < $signed(rs2_data_i));
    assign lt_u = (rs1_data_i < rs2_data_i);

    assign base     = (br_op_i == BR_JALR) ? rs1_data_i : pc_i;
    assign sum      = base + imm_i;
    assign target_o = (br_op_i == BR_JALR) ? {sum[XLEN-1:1], 1'b0} : sum; // jalr clears bit 0

    always_comb begin
        case (br_op_i)
            BR_BEQ:  taken_o = eq;
            BR_BNE:  taken_o = !eq;
            BR_BLT:  taken_o = lt_s;
            BR_BGE:  taken_o = !lt_s;
            BR_BLTU: taken_o = lt_u;
            BR_BGEU: taken_o = !lt_u;
            BR_JAL,
            BR_JALR: taken_o = 1'b1;
            default: taken_o = 1'b0;
        endcase
    end

endmodule

/* logic/alu.sv */
module alu
    import ex_ctrl_pkg::*;
#(
    parameter int XLEN = 64
) (
    input  alu_op_e         alu_op_i,
    input  src_a_e          src_a_i,
    input  src_b_e          src_b_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] rs1_data_i,
    input  logic [XLEN-1:0] rs2_data_i,
    input  logic [XLEN-1:0] imm_i,
    output logic [XLEN-1:0] result_o
);

    localparam int SHW = $clog2(XLEN); // 6 bits at 64, 5 at 32

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [SHW-1:0]  shamt;

    assign op_a  = (src_a_i == SRC_A_PC) ? pc_i : rs1_data_i;
    assign op_b  = (src_b_i == SRC_B_IMM) ? imm_i : rs2_data_i;
    assign shamt = op_b[SHW-1:0];

    always_comb begin
        case (alu_op_i)
            ALU_ADD:    result_o = op_a + op_b;
            ALU_SUB:    result_o = op_a - op_b;
            ALU_SLL:    result_o = op_a << shamt;
            ALU_SLT:    result_o = XLEN'($signed(op_a) < $signed(op_b));
            ALU_SLTU:   result_o = XLEN'(op_a < op_b);
            ALU_XOR:    result_o = op_a ^ op_b;
            ALU_SRL:    result_o = op_a >> shamt;
            ALU_SRA:    result_o = $unsigned($signed(op_a) >>> shamt);
            ALU_OR:     result_o = op_a | op_b;
            ALU_AND:    result_o = op_a & op_b;
            ALU_PASS_B: result_o = op_b;
            default:    result_o = '0;
        endcase
    end

endmodule

/* logic/id_ex_reg.sv */
module id_ex_reg
    import ex_ctrl_pkg::*;
#(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            reset_i,
    input  logic            stall_i,
    input  logic            flush_i,
    input  logic            valid_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] rs1_data_i,
    input  logic [XLEN-1:0] rs2_data_i,
    input  alu_op_e         alu_op_i,
    input  src_a_e          src_a_i,
    input  src_b_e          src_b_i,
    input  br_op_e          br_op_i,
    input  wb_sel_e         wb_sel_i,
    input  logic            rd_we_i,
    input  logic [4:0]      rd_i,
    input  logic [31:0]     imm_i,
    output logic            valid_o,
    output logic [XLEN-1:0] pc_o,
    output logic [XLEN-1:0] rs1_data_o,
    output logic [XLEN-1:0] rs2_data_o,
    output logic [XLEN-1:0] imm_o,
    output alu_op_e         alu_op_o,
    output src_a_e          src_a_o,
    output src_b_e          src_b_o,
    output br_op_e          br_op_o,
    output wb_sel_e         wb_sel_o,
    output logic            rd_we_o,
    output logic [4:0]      rd_o
);

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            valid_o  <= 1'b0;
            alu_op_o <= ALU_ADD;
            src_a_o  <= SRC_A_RS1;
            src_b_o  <= SRC_B_RS2;
            br_op_o  <= BR_NONE;
            wb_sel_o <= WB_ALU;
            rd_we_o  <= 1'b0;
            rd_o     <= 5'd0;
        end else if (!stall_i) begin
            valid_o  <= valid_i;
            alu_op_o <= alu_op_i;
            src_a_o  <= src_a_i;
            src_b_o  <= src_b_i;
            br_op_o  <= br_op_i;
            wb_sel_o <= wb_sel_i;
            rd_we_o  <= rd_we_i;
            rd_o     <= rd_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            pc_o       <= pc_i;
            rs1_data_o <= rs1_data_i;
            rs2_data_o <= rs2_data_i;
            imm_o      <= {{(XLEN-32){imm_i[31]}}, imm_i}; // sign extend to xlen
        end
    end

endmodule

/* logic/inst_decode.sv */
module inst_decode
    import rv_isa_pkg::*;
    import ex_ctrl_pkg::*;
(
    input  logic [31:0] instr_i,
    output alu_op_e     alu_op_o,
    output src_a_e      src_a_o,
    output src_b_e      src_b_o,
    output br_op_e      br_op_o,
    output wb_sel_e     wb_sel_o,
    output logic        rd_we_o,
    output logic [4:0]  rd_o,
    output logic [31:0] imm_o
);

    logic [31:0] imm_i_type;
    logic [31:0] imm_u_type;
    logic [31:0] imm_b_type;
    logic [31:0] imm_j_type;
    logic        we;
    alu_f3_e     f3;

    function automatic alu_op_e alu_from_f3(input alu_f3_e fn, input logic alt);
        alu_op_e op;
        case (fn)
            F3_ADD_SUB: op = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     op = ALU_SLL;
            F3_SLT:     op = ALU_SLT;
            F3_SLTU:    op = ALU_SLTU;
            F3_XOR:     op = ALU_XOR;
            F3_SRL_SRA: op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      op = ALU_OR;
            default:    op = ALU_AND;
        endcase
        return op;
    endfunction

    assign f3 = alu_f3_e'(instr_i[14:12]);
    assign rd_o = instr_i[11:7];

    assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_u_type = {instr_i[31:12], 12'b0};
    assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                         instr_i[11:8], 1'b0};
    assign imm_j_type = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                         instr_i[30:21], 1'b0};

    always_comb begin
        alu_op_o = ALU_ADD;
        src_a_o  = SRC_A_RS1;
        src_b_o  = SRC_B_RS2;
        br_op_o  = BR_NONE;
        wb_sel_o = WB_ALU;
        we       = 1'b0;
        imm_o    = 32'd0;
        case (opcode_e'(instr_i[6:0]))
            OPC_OP: begin
                alu_op_o = alu_from_f3(f3, instr_i[31:25] == FUNCT7_ALT);
                we       = 1'b1;
            end
            OPC_OP_IMM: begin
                // only the shift form has an alternate encoding
                alu_op_o = alu_from_f3(f3, instr_i[ALT_BIT] && (f3 == F3_SRL_SRA));
                src_b_o  = SRC_B_IMM;
                imm_o    = imm_i_type;
                we       = 1'b1;
            end
            OPC_LUI: begin
                alu_op_o = ALU_PASS_B;
                src_b_o  = SRC_B_IMM;
                imm_o    = imm_u_type;
                we       = 1'b1;
            end
            OPC_AUIPC: begin
                src_a_o = SRC_A_PC;
                src_b_o = SRC_B_IMM;
                imm_o   = imm_u_type;
                we      = 1'b1;
            end
            OPC_JAL: begin
                br_op_o  = BR_JAL;
                wb_sel_o = WB_LINK;
                imm_o    = imm_j_type;
                we       = 1'b1;
            end
            OPC_JALR: begin
                br_op_o  = BR_JALR;
                wb_sel_o = WB_LINK;
                imm_o    = imm_i_type;
                we       = 1'b1;
            end
            OPC_BRANCH: begin
                imm_o = imm_b_type;
                case (branch_f3_e'(instr_i[14:12]))
                    F3_BEQ:  br_op_o = BR_BEQ;
                    F3_BNE:  br_op_o = BR_BNE;
                    F3_BLT:  br_op_o = BR_BLT;
                    F3_BGE:  br_op_o = BR_BGE;
                    F3_BLTU: br_op_o = BR_BLTU;
                    F3_BGEU: br_op_o = BR_BGEU;
                    default: br_op_o = BR_NONE; // reserved funct3
                endcase
            end
            default: ; // unknown opcode, no effect
        endcase
    end

    assign rd_we_o = we && (rd_o != 5'd0); // x0 is never written

endmodule

/* logic/ex_ctrl_pkg.sv */
package ex_ctrl_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B // lui
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU,
        BR_JAL,
        BR_JALR
    } br_op_e;

    typedef enum logic {SRC_A_RS1, SRC_A_PC} src_a_e;
    typedef enum logic {SRC_B_RS2, SRC_B_IMM} src_b_e;
    typedef enum logic {WB_ALU, WB_LINK} wb_sel_e; // link is pc + 4

endpackage

/* logic/rv_isa_pkg.sv */
package rv_isa_pkg;

    localparam logic [6:0] FUNCT7_ALT = 7'b0100000; // selects sub and sra
    localparam int unsigned ALT_BIT = 30; // same bit inside an I-type shift immediate

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [2:0] {
        F3_BEQ  = 3'b000,
        F3_BNE  = 3'b001,
        F3_BLT  = 3'b100,
        F3_BGE  = 3'b101,
        F3_BLTU = 3'b110,
        F3_BGEU = 3'b111
    } branch_f3_e;

    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SRL_SRA = 3'b101,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } alu_f3_e;

endpackage
